/* adc_pnmon_pkg.sv */
// Shared types, widths and register map of the ADC PN test-pattern monitor, imported by every block
package adc_pnmon_pkg;

  // Bits per ADC sample, offset binary at the input
  parameter int sample_width = 16;

  // Words in a row needed to gain or lose lock
  parameter int oos_threshold = 16;

  // Pattern opcode, PN9 is x^9+x^5+1 and PN23 is x^23+x^18+1
  typedef enum logic [0:0] {
    PN_SEQ_PN9  = 1'b0,
    PN_SEQ_PN23 = 1'b1
  } pn_seq_e;

  typedef enum logic [0:0] {
    PN_OOS    = 1'b0,
    PN_LOCKED = 1'b1
  } pn_state_e;

  // **********************************************************************
  // Wishbone classic, 4-bit byte address, 32-bit data

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [3:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // Tracker outputs, err is a one-cycle pulse
  typedef struct packed {
    logic oos;
    logic err;
  } pn_status_t;

  parameter logic [3:0] reg_ctrl_addr   = 4'h0;
  parameter logic [3:0] reg_status_addr = 4'h4;
  parameter logic [3:0] reg_errcnt_addr = 4'h8;

endpackage

/* adc_pn_check.sv */
// Input conversion and PN9/PN23 next-word predictor that feeds the lock tracker
`timescale 1ns/1ps

module adc_pn_check #(
  parameter int num_lanes = 4
) (
  input  logic                                             adc_clk,
  input  logic                                             rst_n,
  input  logic                                             adc_valid,
  input  logic [num_lanes*adc_pnmon_pkg::sample_width-1:0] adc_data,
  input  adc_pnmon_pkg::pn_seq_e                           pn_seq,
  input  logic                                             oos,
  output logic                                             word_valid,
  output logic [num_lanes*adc_pnmon_pkg::sample_width-1:0] data_in,
  output logic [num_lanes*adc_pnmon_pkg::sample_width-1:0] data_pn
);

  import adc_pnmon_pkg::*;

  localparam int word_width = num_lanes * sample_width;

  // Longest LFSR supported, PN23
  localparam int lfsr_len = 23;

  logic [word_width-1:0] data_conv;
  logic [word_width-1:0] pn_src;
  logic [word_width-1:0] pn_next;

  // **********************************************************************
  // PN step
  // Seeds the LFSR from the low bits of din and returns the next
  // word_width sequence bits, first bit in the MSB

  function automatic logic [word_width-1:0] pn_run(
    input logic [word_width-1:0] din,
    input int                    hi_tap,
    input int                    lo_tap
  );
    logic [lfsr_len-1:0]   lfsr;
    logic                  fb;
    logic [word_width-1:0] dout;
    lfsr = din[lfsr_len-1:0];
    for (int i = word_width - 1; i >= 0; i--) begin
      fb      = lfsr[hi_tap] ^ lfsr[lo_tap];
      dout[i] = fb;
      lfsr    = {lfsr[lfsr_len-2:0], fb};
    end
    return dout;
  endfunction

  // **********************************************************************
  // Lane reversal and offset binary to two's complement

  always_comb begin
    logic [sample_width-1:0] smp;
    data_conv = '0;
    for (int i = 0; i < num_lanes; i++) begin
      smp = adc_data[i*sample_width +: sample_width];
      data_conv[(num_lanes-1-i)*sample_width +: sample_width] =
        {~smp[sample_width-1], smp[sample_width-2:0]};
    end
  end

  // Reseed from the stream while out of sync, run free once locked
  assign pn_src = oos ? data_in : data_pn;

  // Taps are the LFSR bits for x^9+x^5 and x^23+x^18
  assign pn_next = (pn_seq == PN_SEQ_PN9) ? pn_run(pn_src, 8, 4)
                                          : pn_run(pn_src, 22, 17);

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
    end else begin
      word_valid <= adc_valid;
    end
  end

  // Gaps in adc_valid hold both words, so the predictor skips them
  always_ff @(posedge adc_clk) begin
    if (adc_valid) begin
      data_in <= data_conv;
      data_pn <= pn_next;
    end
  end

endmodule

/* adc_pn_sync.sv */
// Lock tracker that compares converted and predicted words and drives the out-of-sync flag and err pulse
`timescale 1ns/1ps

module adc_pn_sync #(
  parameter int num_lanes = 4
) (
  input  logic                                             adc_clk,
  input  logic                                             rst_n,
  input  logic                                             word_valid,
  input  logic [num_lanes*adc_pnmon_pkg::sample_width-1:0] data_in,
  input  logic [num_lanes*adc_pnmon_pkg::sample_width-1:0] data_pn,
  output adc_pnmon_pkg::pn_status_t                        status
);

  import adc_pnmon_pkg::*;

  localparam logic [4:0] run_last = 5'(oos_threshold - 1);

  logic      match_q;
  logic      valid_q;
  pn_state_e state;
  logic [4:0] run_cnt;
  logic      err_q;

  // All-zero words never count as a match, a dead input would otherwise lock
  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      match_q <= 1'b0;
    end else begin
      valid_q <= word_valid;
      match_q <= (data_in == data_pn) && (data_in != '0);
    end
  end

  // **********************************************************************
  // Lock state machine, run_cnt counts matches in OOS and mismatches in LOCKED

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      state   <= PN_OOS;
      run_cnt <= '0;
      err_q   <= 1'b0;
    end else begin
      err_q <= 1'b0;
      if (valid_q) begin
        case (state)
          PN_OOS: begin
            if (!match_q) begin
              run_cnt <= '0;
            end else if (run_cnt == run_last) begin
              state   <= PN_LOCKED;
              run_cnt <= '0;
            end else begin
              run_cnt <= run_cnt + 5'd1;
            end
          end
          default: begin
            if (match_q) begin
              run_cnt <= '0;
            end else if (run_cnt == run_last) begin
              // Word that drops lock is not reported as an error
              state   <= PN_OOS;
              run_cnt <= '0;
            end else begin
              run_cnt <= run_cnt + 5'd1;
              err_q   <= 1'b1;
            end
          end
        endcase
      end
    end
  end

  assign status.oos = (state == PN_OOS);
  assign status.err = err_q;

endmodule

/* adc_pn_regs.sv */
// Wishbone classic register slave with pattern select, lock status, sticky error and error counter
`timescale 1ns/1ps

module adc_pn_regs (
  input  logic                       adc_clk,
  input  logic                       rst_n,
  input  adc_pnmon_pkg::wb_req_t     wb_req,
  output adc_pnmon_pkg::wb_rsp_t     wb_rsp,
  input  adc_pnmon_pkg::pn_status_t  status,
  output adc_pnmon_pkg::pn_seq_e     pn_seq
);

  import adc_pnmon_pkg::*;

  logic        req;
  logic        wr_en;
  logic        ack_q;
  logic [31:0] rd_data;
  logic [31:0] dat_q;
  logic        err_sticky;
  logic [15:0] err_cnt;

  assign req   = wb_req.cyc && wb_req.stb;
  // Accept only on the first cycle of a request, ack goes out the next edge
  assign wr_en = req && !ack_q && wb_req.we;

  always_comb begin
    case (wb_req.adr)
      reg_ctrl_addr:   rd_data = {31'd0, pn_seq};
      reg_status_addr: rd_data = {30'd0, err_sticky, status.oos};
      reg_errcnt_addr: rd_data = {16'd0, err_cnt};
      default:         rd_data = 32'd0;
    endcase
  end

  // **********************************************************************
  // Handshake

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req && !ack_q;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (req && !ack_q) begin
      dat_q <= rd_data;
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = dat_q;

  // **********************************************************************
  // Registers

  always_ff @(posedge adc_clk) begin
    if (!rst_n) begin
      pn_seq     <= PN_SEQ_PN9;
      err_sticky <= 1'b0;
      err_cnt    <= '0;
    end else begin
      if (wr_en && wb_req.adr == reg_ctrl_addr) begin
        pn_seq <= pn_seq_e'(wb_req.dat[0]);
      end
      // A new error on the clearing cycle still leaves the bit set
      if (status.err) begin
        err_sticky <= 1'b1;
      end else if (wr_en && wb_req.adr == reg_status_addr && wb_req.dat[1]) begin
        err_sticky <= 1'b0;
      end
      if (wr_en && wb_req.adr == reg_ctrl_addr && wb_req.dat[1]) begin
        err_cnt <= {15'd0, status.err};
      end else if (status.err && err_cnt != 16'hffff) begin
        err_cnt <= err_cnt + 16'd1;
      end
    end
  end

endmodule

/* adc_pnmon_top.sv */
// Top level of the ADC PN monitor, wiring the predictor, lock tracker and register slave
`timescale 1ns/1ps

module adc_pnmon_top #(
  parameter int num_lanes = 4
) (
  input  logic                                             adc_clk,
  input  logic                                             rst_n,
  input  logic                                             adc_valid,
  input  logic [num_lanes*adc_pnmon_pkg::sample_width-1:0] adc_data,
  input  adc_pnmon_pkg::wb_req_t                           wb_req,
  output adc_pnmon_pkg::wb_rsp_t                           wb_rsp,
  output adc_pnmon_pkg::pn_status_t                        status
);

  import adc_pnmon_pkg::*;

  localparam int word_width = num_lanes * sample_width;

  pn_seq_e               pn_seq;
  logic                  word_valid;
  logic [word_width-1:0] data_in;
  logic [word_width-1:0] data_pn;

  adc_pn_check #(.num_lanes(num_lanes)) u_check (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .pn_seq     (pn_seq),
    .oos        (status.oos),
    .word_valid (word_valid),
    .data_in    (data_in),
    .data_pn    (data_pn)
  );

  adc_pn_sync #(.num_lanes(num_lanes)) u_sync (
    .adc_clk    (adc_clk),
    .rst_n      (rst_n),
    .word_valid (word_valid),
    .data_in    (data_in),
    .data_pn    (data_pn),
    .status     (status)
  );

  adc_pn_regs u_regs (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .status  (status),
    .pn_seq  (pn_seq)
  );

endmodule

/* adc_pnmon_checker.sv */
// Assertions on the Wishbone handshake and lock status, bound into the monitor top level
`timescale 1ns/1ps

module adc_pnmon_checker (
  input logic                      adc_clk,
  input logic                      rst_n,
  input adc_pnmon_pkg::wb_req_t    wb_req,
  input adc_pnmon_pkg::wb_rsp_t    wb_rsp,
  input adc_pnmon_pkg::pn_status_t status
);

  import adc_pnmon_pkg::*;

  // Number of failed assertions
  int fail_cnt = 0;

  // **********************************************************************
  // Bus handshake

  ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
    else begin
      fail_cnt++;
      $error("ack held high for two cycles");
    end

  ack_after_req: assert property (@(posedge adc_clk) disable iff (!rst_n)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else begin
      fail_cnt++;
      $error("ack without a request on the cycle before");
    end

  // **********************************************************************
  // Lock status

  err_only_locked: assert property (@(posedge adc_clk) disable iff (!rst_n)
    !(status.err && status.oos))
    else begin
      fail_cnt++;
      $error("err pulse while out of sync");
    end

  oos_after_reset: assert property (@(posedge adc_clk)
    $rose(rst_n) |-> status.oos)
    else begin
      fail_cnt++;
      $error("oos not set when reset is released");
    end

endmodule

/* tb_adc_pnmon.sv */
// Testbench for the ADC PN monitor, driving PN streams and Wishbone accesses; run by run_sim.sh
`timescale 1ns/1ps

module tb_adc_pnmon;

  import adc_pnmon_pkg::*;

  localparam int num_lanes  = 4;
  localparam int word_width = num_lanes * sample_width;
  // Tests need roughly 1000 cycles
  localparam int max_cycles = 6000;
  localparam pn_status_t st_oos    = '{oos: 1'b1, err: 1'b0};
  localparam pn_status_t st_locked = '{oos: 1'b0, err: 1'b0};

  logic                  adc_clk;
  logic                  rst_n;
  logic                  adc_valid;
  logic [word_width-1:0] adc_data;
  wb_req_t               wb_req;
  wb_rsp_t               wb_rsp;
  pn_status_t            status;

  pn_seq_e               cur_seq;
  logic [word_width-1:0] last_word;
  logic [31:0]           rdata;
  int                    cycles = 0;
  int                    err_seen = 0;
  bit                    err_allowed = 1'b0;
  int                    k;
  int                    base;

  adc_pnmon_top #(.num_lanes(num_lanes)) DUT (
    .adc_clk   (adc_clk),
    .rst_n     (rst_n),
    .adc_valid (adc_valid),
    .adc_data  (adc_data),
    .wb_req    (wb_req),
    .wb_rsp    (wb_rsp),
    .status    (status)
  );

  bind adc_pnmon_top adc_pnmon_checker u_chk (
    .adc_clk (adc_clk),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .status  (status)
  );

  // **********************************************************************
  // Reference model
  // Bit k of the stream is bit k-9 xor bit k-5 (PN9) or k-23 xor k-18 (PN23)

  function automatic logic [word_width-1:0] pn_step(input pn_seq_e seq,
                                                    input logic [word_width-1:0] prev);
    logic [word_width+22:0] bits;
    logic [word_width-1:0]  w;
    int                     lag_a;
    int                     lag_b;
    lag_a = (seq == PN_SEQ_PN9) ? 9 : 23;
    lag_b = (seq == PN_SEQ_PN9) ? 5 : 18;
    // Oldest history bit first, prev[0] is the newest
    for (int i = 0; i < 23; i++) begin
      bits[i] = prev[22-i];
    end
    for (int i = 23; i < word_width + 23; i++) begin
      bits[i] = bits[i-lag_a] ^ bits[i-lag_b];
      w[word_width+22-i] = bits[i];
    end
    return w;
  endfunction

  // Undo lane reversal and sign conversion to get the raw ADC word
  function automatic logic [word_width-1:0] to_adc(input logic [word_width-1:0] d);
    logic [sample_width-1:0] s;
    logic [word_width-1:0]   a;
    a = '0;
    for (int i = 0; i < num_lanes; i++) begin
      s = d[(num_lanes-1-i)*sample_width +: sample_width];
      a[i*sample_width +: sample_width] = {~s[sample_width-1], s[sample_width-2:0]};
    end
    return a;
  endfunction

  // **********************************************************************
  // Compare tasks

  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_status(input string name, input pn_status_t exp, input pn_status_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected oos=%0b err=%0b, actual oos=%0b err=%0b",
               name, exp.oos, exp.err, act.oos, act.err);
      abort_run();
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_seq(input string name, input pn_seq_e exp, input pn_seq_e act);
    if (act !== exp) begin
      $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  // **********************************************************************
  // Stimulus

  task automatic drive_word(input logic valid, input logic [word_width-1:0] d);
    @(posedge adc_clk);
    #1;
    adc_valid = valid;
    adc_data  = to_adc(d);
  endtask

  task automatic idle(input int n);
    repeat (n) drive_word(1'b0, '0);
  endtask

  task automatic send_pn(input int n, input bit gappy);
    for (int i = 0; i < n; i++) begin
      if (gappy && ($urandom % 4) == 0) begin
        idle(int'($urandom_range(1, 3)));
      end
      last_word = pn_step(cur_seq, last_word);
      drive_word(1'b1, last_word);
    end
  endtask

  task automatic bus_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                          output logic [31:0] rdat);
    int wait_cnt;
    wait_cnt = 0;
    @(posedge adc_clk);
    #1;
    adc_valid = 1'b0;
    wb_req    = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    do begin
      @(posedge adc_clk);
      #1;
      wait_cnt++;
      if (wait_cnt > 8) begin
        $display("No Wishbone ack within 8 cycles for address %0h", adr);
        abort_run();
      end
    end while (!wb_rsp.ack);
    rdat   = wb_rsp.dat;
    wb_req = '0;
  endtask

  task automatic write_reg(input logic [3:0] adr, input logic [31:0] wdat);
    logic [31:0] unused_dat;
    bus_xfer(1'b1, adr, wdat, unused_dat);
  endtask

  task automatic read_check(input string name, input logic [3:0] adr, input logic [31:0] exp);
    logic [31:0] dat;
    bus_xfer(1'b0, adr, 32'h0, dat);
    check_reg(name, exp, dat);
  endtask

  // **********************************************************************
  // Clock, timeout and err monitor

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  always @(posedge adc_clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Run did not finish within %0d cycles", max_cycles);
      abort_run();
    end
  end

  always @(negedge adc_clk) begin
    if (rst_n && status.err) begin
      err_seen++;
      if (!err_allowed) begin
        $display("Unexpected err pulse at cycle %0d", cycles);
        abort_run();
      end
    end
  end

  initial begin
    rst_n     = 1'b0;
    adc_valid = 1'b0;
    adc_data  = '0;
    wb_req    = '0;
    cur_seq   = PN_SEQ_PN9;
    last_word = '0;
    void'($urandom(32'ha5fc));
    repeat (3) @(posedge adc_clk);
    #1;
    rst_n = 1'b1;

    // Reset state
    check_status("reset status", st_oos, status);
    read_check("reset ctrl", reg_ctrl_addr, 32'h0);
    read_check("reset status reg", reg_status_addr, 32'h1);
    read_check("reset errcnt", reg_errcnt_addr, 32'h0);

    // PN9 lock from a random seed, then a long clean run
    last_word = {$urandom, $urandom} | 64'd1;
    send_pn(20, 1'b0);
    idle(4);
    check_status("pn9 lock", st_locked, status);
    send_pn(300, 1'b0);
    idle(4);
    check_status("pn9 run", st_locked, status);
    read_check("pn9 errcnt", reg_errcnt_addr, 32'h0);

    // Loss of lock on all-zero data
    err_allowed = 1'b1;
    base = err_seen;
    repeat (15) drive_word(1'b1, '0);
    idle(4);
    check_status("zero words 15", st_locked, status);
    drive_word(1'b1, '0);
    idle(4);
    check_status("zero words 16", st_oos, status);
    read_check("lock loss errcnt", reg_errcnt_addr, 32'd15);
    check_reg("lock loss err pulses", 32'd15, 32'(err_seen - base));
    err_allowed = 1'b0;

    // Select PN23, clear count and sticky, then relock
    write_reg(reg_ctrl_addr, 32'h3);
    write_reg(reg_status_addr, 32'h2);
    bus_xfer(1'b0, reg_ctrl_addr, 32'h0, rdata);
    check_seq("ctrl select", PN_SEQ_PN23, pn_seq_e'(rdata[0]));
    cur_seq   = PN_SEQ_PN23;
    last_word = {$urandom, $urandom} | 64'd1;
    send_pn(20, 1'b0);
    idle(4);
    check_status("pn23 relock", st_locked, status);
    read_check("relock status reg", reg_status_addr, 32'h0);

    // Isolated single-bit errors
    err_allowed = 1'b1;
    base = err_seen;
    k = int'($urandom_range(3, 8));
    for (int i = 0; i < k; i++) begin
      send_pn(int'($urandom_range(4, 10)), 1'b0);
      last_word = pn_step(cur_seq, last_word);
      drive_word(1'b1, last_word ^ (64'd1 << $urandom_range(0, 63)));
    end
    send_pn(4, 1'b0);
    idle(4);
    err_allowed = 1'b0;
    check_status("pn23 after errors", st_locked, status);
    read_check("error count", reg_errcnt_addr, 32'(k));
    check_reg("error pulses", 32'(k), 32'(err_seen - base));
    read_check("sticky set", reg_status_addr, 32'h2);
    write_reg(reg_status_addr, 32'h2);
    read_check("sticky cleared", reg_status_addr, 32'h0);
    write_reg(reg_ctrl_addr, 32'h3);
    read_check("count cleared", reg_errcnt_addr, 32'h0);

    // Gaps in adc_valid inside a locked stream
    send_pn(200, 1'b1);
    idle(4);
    check_status("valid gaps", st_locked, status);
    read_check("valid gaps errcnt", reg_errcnt_addr, 32'h0);

    if (DUT.u_chk.fail_cnt != 0) begin
      $display("Checker reported %0d assertion failures", DUT.u_chk.fail_cnt);
      $display("** FAIL **");
      $fatal(1, "assertion failures");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* adc_pnmon.f */
adc_pnmon_pkg.sv
adc_pn_check.sv
adc_pn_sync.sv
adc_pn_regs.sv
adc_pnmon_top.sv
adc_pnmon_checker.sv
tb_adc_pnmon.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the ADC PN monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_adc_pnmon \
  -f adc_pnmon.f \
  -o sim_adc_pnmon

# The simulator exits non-zero on a fatal error, the search decides the result
sim_out=$(./obj_dir/sim_adc_pnmon 2>&1) || true
echo "$sim_out"
if grep -qxF '** PASS **' <<< "$sim_out"; then
  exit 0
fi
exit 1
